// File: Makefile
TOP := branch_core_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir

// File: filelist.f
rtl/defines.sv
rtl/pc_adder.sv
rtl/regfile.sv
rtl/pc_stage.sv
rtl/branch_core.sv
sim/branch_core_assertions.sv
sim/branch_core_tb.sv

// File: rtl/branch_core.sv
`timescale 1ns/100ps

module branch_core (
	input  logic             clk,
	input  logic             arst_n,

	input  logic             instr_valid,
	input  defines::instr_t  instr,
	input  defines::reg_wr_t ext_wr,

	output defines::data_t   pc,
	output logic             redirect
);

	import defines::*;

	// source operands at rs1 and rs2 of instr
	data_t rs1_data;
	data_t rs2_data;

	// target and select from the adder
	data_t pc_bj;
	logic  pc_sel;

	// arbitrated write into the register file
	reg_wr_t rf_wr;

	regfile u_regfile (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs1_idx  (instr.rs1),
		.rs2_idx  (instr.rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wr       (rf_wr)
	);

	pc_adder u_pc_adder (
		.instr  (instr),
		.pc     (pc),
		.rs1    (rs1_data),
		.rs2    (rs2_data),
		.pc_bj  (pc_bj),
		.pc_sel (pc_sel)
	);

	pc_stage u_pc_stage (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc_sel      (pc_sel),
		.pc_bj       (pc_bj),
		.ext_wr      (ext_wr),
		.pc          (pc),
		.redirect    (redirect),
		.rf_wr       (rf_wr)
	);

endmodule

// File: rtl/defines.sv
package defines;

	// core width, fixed at RV32
	localparam int XLEN = 32;

	// architectural register count and index width
	localparam int NUM_REGS  = 32;
	localparam int REG_IDX_W = 5;

	typedef logic [XLEN-1:0]      data_t;     // register values, pc values and targets
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [6:0]           opcode_t;
	typedef logic [2:0]           funct3_t;
	typedef logic [6:0]           funct7_t;

	// pc after reset
	localparam data_t RESET_VECTOR = 32'h0000_1000;

	// sequential step between instructions
	localparam data_t PC_STEP = 32'd4;

	// control flow opcodes
	localparam opcode_t B    = 7'b1100011;
	localparam opcode_t JAL  = 7'b1101111;
	localparam opcode_t JALR = 7'b1100111;

	// branch conditions in funct3
	localparam funct3_t BEQ  = 3'd0;
	localparam funct3_t BNE  = 3'd1;
	localparam funct3_t BLT  = 3'd4;
	localparam funct3_t BGE  = 3'd5;
	localparam funct3_t BLTU = 3'd6;
	localparam funct3_t BGEU = 3'd7;

	// R-type field view, msb first
	typedef struct packed {
		funct7_t  funct7;  // [31:25]
		reg_idx_t rs2;     // [24:20]
		reg_idx_t rs1;     // [19:15]
		funct3_t  funct3;  // [14:12]
		reg_idx_t rd;      // [11:7]
		opcode_t  opcode;  // [6:0]
	} instr_t;

	// one register file write request
	typedef struct packed {
		logic     en;
		reg_idx_t rd;
		data_t    data;
	} reg_wr_t;

	// B-type immediate, counted in halfwords so bit 0 is always zero
	function automatic data_t get_imm(instr_t ins);
		logic [31:0] w;
		w = ins;
		return {
			{(XLEN-12){w[31]}},  // imm[31:12]
			w[7],                // imm[11]
			w[30:25],            // imm[10:5]
			w[11:8],             // imm[4:1]
			1'b0
		};
	endfunction

	// J-type immediate for jal
	function automatic data_t get_j_imm(instr_t ins);
		logic [31:0] w;
		w = ins;
		return {
			{(XLEN-20){w[31]}},  // imm[31:20]
			w[19:12],            // imm[19:12]
			w[20],               // imm[11]
			w[30:21],            // imm[10:1]
			1'b0
		};
	endfunction

	// I-type immediate for jalr, byte granular
	function automatic data_t get_i_imm(instr_t ins);
		logic [31:0] w;
		w = ins;
		return {
			{(XLEN-12){w[31]}},
			w[31:20]
		};
	endfunction

endpackage

// File: rtl/pc_adder.sv
`timescale 1ns/100ps

module pc_adder (
	input  defines::instr_t instr,
	input  defines::data_t  pc,
	input  defines::data_t  rs1,
	input  defines::data_t  rs2,

	output defines::data_t  pc_bj,   // branch or jump target
	output logic            pc_sel   // 1 takes pc_bj, 0 falls through to pc + 4
);

	import defines::*;

	opcode_t opcode;
	funct3_t funct3;

	logic is_branch;
	logic is_jal;
	logic is_jalr;

	// rs2 - rs1 one bit wider so the borrow survives
	logic [XLEN:0] diff_unsign;
	logic [XLEN:0] diff_sign;

	logic beq_take;
	logic bne_take;
	logic blt_take;
	logic bge_take;
	logic bltu_take;
	logic bgeu_take;

	logic cond_hit;
	logic branch_taken;

	data_t base;
	data_t imm;
	data_t sum;

	assign opcode = instr.opcode;
	assign funct3 = instr.funct3;

	assign is_branch = (opcode == B);
	assign is_jal    = (opcode == JAL);
	assign is_jalr   = (opcode == JALR);

	assign diff_unsign = {1'b0, rs2} - {1'b0, rs1};
	assign diff_sign   = {rs2[XLEN-1], rs2} - {rs1[XLEN-1], rs1};  // cannot overflow

	assign beq_take  = (diff_unsign == '0);
	assign bne_take  = ~beq_take;
	assign blt_take  = ~diff_sign[XLEN] & ~beq_take;    // rs2 - rs1 > 0
	assign bltu_take = ~diff_unsign[XLEN] & ~beq_take;  // no borrow and nonzero
	assign bge_take  = ~blt_take;
	assign bgeu_take = ~bltu_take;

	always_comb begin
		case (funct3)
			BEQ:     cond_hit = beq_take;
			BNE:     cond_hit = bne_take;
			BLT:     cond_hit = blt_take;
			BGE:     cond_hit = bge_take;
			BLTU:    cond_hit = bltu_take;
			BGEU:    cond_hit = bgeu_take;
			default: cond_hit = 1'b0;  // funct3 2 and 3 are not branches
		endcase
	end

	assign branch_taken = is_branch & cond_hit;

	// jalr adds to rs1, everything else to pc
	assign base = is_jalr ? rs1 : pc;

	always_comb begin
		if (is_jal)
			imm = get_j_imm(instr);
		else if (is_jalr)
			imm = get_i_imm(instr);
		else
			imm = get_imm(instr);
	end

	assign sum = base + imm;

	// jalr target drops bit 0
	assign pc_bj = is_jalr ? {sum[XLEN-1:1], 1'b0} : sum;

	assign pc_sel = branch_taken | is_jal | is_jalr;

endmodule

// File: rtl/pc_stage.sv
`timescale 1ns/100ps

module pc_stage (
	input  logic             clk,
	input  logic             arst_n,

	input  logic             instr_valid,
	input  defines::instr_t  instr,

	input  logic             pc_sel,
	input  defines::data_t   pc_bj,

	input  defines::reg_wr_t ext_wr,   // write-back from non-control instructions

	output defines::data_t   pc,
	output logic             redirect,
	output defines::reg_wr_t rf_wr
);

	import defines::*;

	data_t pc_plus4;
	data_t pc_next;

	logic is_jump;
	logic link_en;
	logic ext_en;

	reg_wr_t link_wr;

	// shared by fall-through and the link value
	assign pc_plus4 = pc + PC_STEP;

	assign pc_next = pc_sel ? pc_bj : pc_plus4;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= RESET_VECTOR;
		end else if (instr_valid) begin
			pc <= pc_next;
		end
	end

	// flags the flow change of the instruction just accepted
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			redirect <= 1'b0;
		end else begin
			redirect <= instr_valid & pc_sel;  // idle cycle clears it
		end
	end

	assign is_jump = (instr.opcode == JAL) || (instr.opcode == JALR);

	// link lands at the same edge that moves pc
	assign link_en = instr_valid && is_jump && (instr.rd != '0);

	always_comb begin
		link_wr.en   = link_en;
		link_wr.rd   = instr.rd;
		link_wr.data = pc_plus4;
	end

	// x0 writes are dropped here already
	assign ext_en = ext_wr.en && (ext_wr.rd != '0);

	// link write beats the external port
	always_comb begin
		if (link_en) begin
			rf_wr = link_wr;
		end else begin
			rf_wr    = ext_wr;
			rf_wr.en = ext_en;
		end
	end

endmodule

// File: rtl/regfile.sv
`timescale 1ns/100ps

module regfile (
	input  logic              clk,
	input  logic              arst_n,

	input  defines::reg_idx_t rs1_idx,
	input  defines::reg_idx_t rs2_idx,
	output defines::data_t    rs1_data,
	output defines::data_t    rs2_data,

	input  defines::reg_wr_t  wr
);

	import defines::*;

	// x1..x31 only, x0 has no storage
	data_t regs [1:NUM_REGS-1];

	logic wr_hit;

	assign wr_hit = wr.en && (wr.rd != '0);  // writes to x0 vanish

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_hit) begin
			regs[wr.rd] <= wr.data;
		end
	end

	// asynchronous read, no write bypass
	function automatic data_t read_port(reg_idx_t idx);
		data_t val;
		if (idx == '0)
			val = '0;
		else
			val = regs[idx];
		return val;
	endfunction

	always_comb begin
		rs1_data = read_port(rs1_idx);
	end

	always_comb begin
		rs2_data = read_port(rs2_idx);
	end

endmodule

// File: sim/branch_core_assertions.sv
`timescale 1ns/100ps

module branch_core_assertions (
	input logic             clk,
	input logic             arst_n,
	input logic             instr_valid,
	input defines::instr_t  instr,
	input defines::data_t   pc,
	input defines::reg_wr_t rf_wr
);

	import defines::*;

	logic jalr_acc;

	assign jalr_acc = instr_valid && (instr.opcode == JALR);

	// only jalr may leave the word grid
	pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		(!jalr_acc && pc[1:0] == 2'b00) |=> (pc[1:0] == 2'b00))
		else $error("pc lost word alignment without an accepted jalr");

	pc_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!instr_valid |=> $stable(pc))
		else $error("pc moved after a cycle without a valid instruction");

	no_x0_write: assert property (@(posedge clk) disable iff (!arst_n)
		rf_wr.en |-> (rf_wr.rd != '0))
		else $error("register file write enabled for x0");

endmodule

bind pc_stage branch_core_assertions u_assertions (
	.clk         (clk),
	.arst_n      (arst_n),
	.instr_valid (instr_valid),
	.instr       (instr),
	.pc          (pc),
	.rf_wr       (rf_wr)
);

// File: sim/branch_core_tb.sv
`timescale 1ns/100ps

module branch_core_tb;

	import defines::*;

	localparam int RESET_CYCLES = 10;
	localparam int CLK_PERIOD   = 10;

	// instruction count per test group for the watchdog budget
	localparam int N_IDLE    = 2;
	localparam int N_PLAIN   = 40;
	localparam int N_EDGE    = 6 + 6 * 5;
	localparam int N_RAND    = 6 * 8 * 3;
	localparam int N_JUMP    = 6 * 2;
	localparam int N_X0      = 4;
	localparam int N_LINK    = 3 * 2;
	localparam int NUM_INSTR = N_IDLE + N_PLAIN + N_EDGE + N_RAND + N_JUMP + N_X0 + N_LINK;

	typedef struct packed {
		data_t pc;
		logic  redirect;
	} next_t;

	logic    clk;
	logic    arst_n;
	logic    instr_valid;
	instr_t  instr;
	reg_wr_t ext_wr;
	data_t   pc;
	logic    redirect;

	int seed;
	int num_applied;
	int num_checked;

	data_t   regs_m [0:NUM_REGS-1];  // register model with x0 held at zero
	data_t   pc_m;
	funct3_t conds [0:5];

	next_t exp_q [$];
	string name_q [$];

	branch_core dut0 (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.ext_wr      (ext_wr),
		.pc          (pc),
		.redirect    (redirect)
	);

	always #5 clk = ~clk;

	// next pc and redirect straight from the ISA rules
	function automatic next_t expected_next(instr_t ins, data_t cur_pc, data_t a, data_t b);
		logic [31:0]        w;
		logic signed [31:0] b_off;
		logic signed [31:0] j_off;
		logic signed [31:0] i_off;
		logic               taken;
		next_t              n;
		w = ins;
		b_off = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
		j_off = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
		i_off = 32'($signed(w[31:20]));
		case (ins.funct3)
			BEQ:     taken = (a == b);
			BNE:     taken = (a != b);
			BLT:     taken = ($signed(a) < $signed(b));
			BGE:     taken = ($signed(a) >= $signed(b));
			BLTU:    taken = (a < b);
			BGEU:    taken = (a >= b);
			default: taken = 1'b0;
		endcase
		n.redirect = 1'b1;
		if (ins.opcode == JAL) begin
			n.pc = cur_pc + j_off;
		end else if (ins.opcode == JALR) begin
			n.pc = (a + i_off) & ~32'd1;
		end else if (ins.opcode == B && taken) begin
			n.pc = cur_pc + b_off;
		end else begin
			n.pc = cur_pc + 32'd4;
			n.redirect = 1'b0;
		end
		return n;
	endfunction

	task automatic check_pc(string tname, data_t expected, data_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: pc expected %h, actual %h", tname, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "pc mismatch");
		end
	endtask

	task automatic check_redirect(string tname, logic expected, logic actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: redirect expected %b, actual %b", tname, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "redirect mismatch");
		end
	endtask

	function automatic reg_idx_t rand_reg();
		return reg_idx_t'(1 + {$random(seed)} % 31);  // x1..x31
	endfunction

	// random non control word with bit 4 of a control opcode flipped
	function automatic instr_t rand_plain();
		instr_t ins;
		ins = $random(seed);
		if (ins.opcode == B || ins.opcode == JAL || ins.opcode == JALR)
			ins.opcode[4] = ~ins.opcode[4];
		return ins;
	endfunction

	function automatic instr_t make_branch(funct3_t f3, reg_idx_t r1, reg_idx_t r2);
		instr_t ins;
		ins = $random(seed);
		ins.opcode = B;
		ins.funct3 = f3;
		ins.rs1 = r1;
		ins.rs2 = r2;
		ins.rd[1] = 1'b0;  // imm[1] cleared for word aligned targets
		return ins;
	endfunction

	function automatic instr_t make_jal(reg_idx_t rd);
		instr_t ins;
		ins = $random(seed);
		ins.opcode = JAL;
		ins.rd = rd;
		ins.rs2[1] = 1'b0;  // imm[1]
		return ins;
	endfunction

	// imm[0] stays random so the cleared lsb gets exercised
	function automatic instr_t make_jalr(reg_idx_t rd, reg_idx_t r1);
		instr_t ins;
		ins = $random(seed);
		ins.opcode = JALR;
		ins.funct3 = 3'd0;
		ins.rd = rd;
		ins.rs1 = r1;
		ins.rs2[1] = 1'b0;
		return ins;
	endfunction

	// drive one cycle, queue its expectation, then step the models
	task automatic apply(string tname, logic valid, instr_t ins, reg_wr_t wr);
		next_t e;
		logic  link;
		@(negedge clk);
		instr_valid = valid;
		instr = ins;
		ext_wr = wr;
		if (valid) begin
			e = expected_next(ins, pc_m, regs_m[ins.rs1], regs_m[ins.rs2]);
		end else begin
			e.pc = pc_m;
			e.redirect = 1'b0;
		end
		exp_q.push_back(e);
		name_q.push_back(tname);
		link = valid && (ins.opcode == JAL || ins.opcode == JALR) && (ins.rd != '0);
		if (link)
			regs_m[ins.rd] = pc_m + 32'd4;
		else if (wr.en && wr.rd != '0)
			regs_m[wr.rd] = wr.data;  // ext write only survives without a link
		if (valid)
			pc_m = e.pc;
		num_applied++;
	endtask

	task automatic load_reg(string tname, reg_idx_t idx, data_t val);
		reg_wr_t wr;
		wr.en = 1'b1;
		wr.rd = idx;
		wr.data = val;
		apply(tname, 1'b1, rand_plain(), wr);
	endtask

	// registered outputs are stable shortly after the edge
	always @(posedge clk) begin : compare
		next_t e;
		string tname;
		#2;
		if (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			tname = name_q.pop_front();
			check_pc(tname, e.pc, pc);
			check_redirect(tname, e.redirect, redirect);
			num_checked++;
		end
	end

	initial begin : watchdog
		#(RESET_CYCLES * CLK_PERIOD + NUM_INSTR * CLK_PERIOD * 4);
		$display("run hung, the tests did not finish within the time budget");
		$display("STATUS: FAIL");
		$fatal(1, "watchdog timeout");
	end

	initial begin : stimulus
		reg_wr_t  no_wr;
		reg_wr_t  wr;
		reg_idx_t r1;
		reg_idx_t r2;
		reg_idx_t rl;
		seed = 90053;
		clk = 1'b0;
		arst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		ext_wr = '0;
		no_wr = '0;
		num_applied = 0;
		num_checked = 0;
		conds = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
		for (int i = 0; i < NUM_REGS; i++)
			regs_m[i] = '0;
		pc_m = RESET_VECTOR;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;
		check_pc("reset", RESET_VECTOR, pc);
		check_redirect("reset", 1'b0, redirect);

		// a jump on the bus without valid must do nothing
		repeat (N_IDLE) apply("idle", 1'b0, make_jal(rand_reg()), no_wr);

		for (int i = 0; i < N_PLAIN; i++) begin
			wr.en = (i % 8 != 7);
			wr.rd = (i % 10 == 0) ? 5'd0 : rand_reg();  // some writes aimed at x0
			wr.data = $random(seed);
			apply("plain", 1'b1, rand_plain(), wr);
		end

		load_reg("edge_load", 5'd5, 32'h1234_5678);
		load_reg("edge_load", 5'd6, 32'h1234_5678);
		load_reg("edge_load", 5'd7, 32'h8000_0000);
		load_reg("edge_load", 5'd8, 32'h7fff_ffff);
		load_reg("edge_load", 5'd9, 32'hffff_ffff);
		load_reg("edge_load", 5'd10, 32'h0000_0001);
		for (int c = 0; c < 6; c++) begin
			apply("branch_equal", 1'b1, make_branch(conds[c], 5'd5, 5'd6), no_wr);
			apply("branch_min_max", 1'b1, make_branch(conds[c], 5'd7, 5'd8), no_wr);
			apply("branch_max_min", 1'b1, make_branch(conds[c], 5'd8, 5'd7), no_wr);
			apply("branch_neg_pos", 1'b1, make_branch(conds[c], 5'd9, 5'd10), no_wr);
			apply("branch_pos_neg", 1'b1, make_branch(conds[c], 5'd10, 5'd9), no_wr);
		end

		for (int c = 0; c < 6; c++) begin
			for (int k = 0; k < 8; k++) begin
				r1 = rand_reg();
				r2 = rand_reg();
				load_reg("branch_rand_load", r1, $random(seed));
				load_reg("branch_rand_load", r2, $random(seed));
				apply($sformatf("branch_rand f3=%0d", conds[c]), 1'b1,
					make_branch(conds[c], r1, r2), no_wr);
			end
		end

		for (int k = 0; k < 6; k++) begin
			rl = rand_reg();
			apply("jal", 1'b1, make_jal(rl), no_wr);
			apply("jalr_via_link", 1'b1, make_jalr((k % 2 == 0) ? 5'd0 : rand_reg(), rl), no_wr);
		end

		load_reg("zero_load", 5'd11, '0);
		apply("jal_x0", 1'b1, make_jal(5'd0), no_wr);
		// idle right after a redirect must clear it and hold pc
		apply("idle_after_jal", 1'b0, make_jal(rand_reg()), no_wr);
		apply("beq_x0", 1'b1, make_branch(BEQ, 5'd0, 5'd11), no_wr);

		// same cycle ext write to the link register is dropped
		for (int k = 0; k < 3; k++) begin
			rl = rand_reg();
			wr.en = 1'b1;
			wr.rd = rl;
			wr.data = $random(seed);
			apply("jal_vs_ext_wr", 1'b1, make_jal(rl), wr);
			apply("jalr_after_drop", 1'b1, make_jalr(rand_reg(), rl), no_wr);
		end

		repeat (2) @(negedge clk);  // last compare runs before this
		if (num_checked == num_applied) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("only %0d of %0d applied cycles were checked", num_checked, num_applied);
			$display("STATUS: FAIL");
			$fatal(1, "missing checks");
		end
	end

endmodule
